/* Bender.yml */
package:
  name: rename_unit

sources:
  - common/regNumPkg.sv
  - common/renamePortPkg.sv
  - rename/freeList.sv
  - rename/renameMapTable.sv
  - rename/retireMapTable.sv
  - rename/renameLogic.sv
  - rtl/renameUnit.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/renameUnitTb.sv

/* common/regNumPkg.sv */
/*
 * Register number space
 * Architectural and physical register counts plus the
 * number types shared by the rename stage
 */
package regNumPkg;

    // Architectural register file
    localparam int logRegNum = 16;
    localparam int logRegWidth = $clog2(logRegNum);

    // Physical register file
    localparam int physRegNum = 32;
    localparam int physRegWidth = $clog2(physRegNum);

    // Free list must be able to report a completely full state
    localparam int freeCountWidth = physRegWidth + 1;

    // Logical register number
    typedef logic [logRegWidth-1:0] logRegT;

    // Physical register number
    typedef logic [physRegWidth-1:0] physRegT;

    // Free-list occupancy from 0 up to physRegNum
    typedef logic [freeCountWidth-1:0] freeCountT;

endpackage

/* common/renamePortPkg.sv */
/*
 * Rename stage port structs
 * Per-lane request, response and commit records
 */
package renamePortPkg;

    import regNumPkg::*;

    // One instruction entering rename
    typedef struct packed {
        logic   valid;
        logic   writeReg;
        logRegT logDst;
        logRegT logSrc1;
        logRegT logSrc2;
    } renameReqT;

    // Physical names handed back for one lane
    typedef struct packed {
        physRegT phyDst;
        physRegT phySrc1;
        physRegT phySrc2;
        physRegT phyPrev;
    } renameRespT;

    // One retiring instruction
    // phyPrev goes back to the free list, phyDst becomes committed
    typedef struct packed {
        logic    valid;
        logic    writeReg;
        logRegT  logDst;
        physRegT phyDst;
        physRegT phyPrev;
    } commitT;

endpackage

/* rename/freeList.sv */
/*
 * Physical register free list
 * Circular buffer with multi-pop from the head, compacted multi-push
 * at the tail and a committed head used to rewind after a squash
 */
`timescale 1ns/100ps

module freeList import regNumPkg::*; #(
    parameter int renameWidth = 2,
    parameter int commitWidth = 2
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [$clog2(renameWidth+1)-1:0]   popCount,
    output physRegT [renameWidth-1:0]          popped,
    input  logic [commitWidth-1:0]             pushValid,
    input  physRegT [commitWidth-1:0]          pushData,
    input  logic [$clog2(commitWidth+1)-1:0]   commitAdvance,
    input  logic                               rewind,
    output freeCountT                          count
);

    // Only registers beyond the architectural set ever sit here
    localparam int depth = physRegNum - logRegNum;
    localparam int idxW = $clog2(depth);
    localparam int ptrW = idxW + 1;
    localparam int pushW = $clog2(commitWidth + 1);

    physRegT entries [depth];

    // Pointers carry one wrap bit above the index
    logic [ptrW-1:0] head;
    logic [ptrW-1:0] tail;
    logic [ptrW-1:0] commitHead;
    logic [ptrW-1:0] tailNext;
    logic [ptrW-1:0] commitHeadNext;
    logic [ptrW-1:0] rewindCount;

    logic [idxW-1:0]  pushSlot [commitWidth];
    logic [pushW-1:0] pushNum;

    // Look ahead of the head so the popped values are ready this cycle
    always_comb begin
        for (int i = 0; i < renameWidth; i++) begin
            popped[i] = entries[head[idxW-1:0] + idxW'(i)];
        end
    end

    // Valid push lanes fill consecutive slots from the tail
    always_comb begin
        pushNum = '0;
        for (int i = 0; i < commitWidth; i++) begin
            pushSlot[i] = tail[idxW-1:0] + idxW'(pushNum);
            if (pushValid[i]) begin
                pushNum = pushNum + 1'b1;
            end
        end
    end

    assign tailNext = tail + ptrW'(pushNum);
    assign commitHeadNext = commitHead + ptrW'(commitAdvance);
    assign rewindCount = tailNext - commitHeadNext;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            head <= '0;
            tail <= ptrW'(depth);
            commitHead <= '0;
            count <= freeCountT'(depth);
            for (int i = 0; i < depth; i++) begin
                entries[i] <= physRegT'(logRegNum + i);
            end
        end else begin
            for (int i = 0; i < commitWidth; i++) begin
                if (pushValid[i]) begin
                    entries[pushSlot[i]] <= pushData[i];
                end
            end
            tail <= tailNext;
            commitHead <= commitHeadNext;
            if (rewind) begin
                // Everything taken past the committed head comes back
                head <= commitHeadNext;
                count <= freeCountT'(rewindCount);
            end else begin
                head <= head + ptrW'(popCount);
                count <= count + freeCountT'(pushNum) - freeCountT'(popCount);
            end
        end
    end

endmodule

/* rename/renameLogic.sv */
/*
 * Rename controller
 * Allocates destinations, bypasses names within a group, releases
 * registers at commit and sequences the map rebuild after recovery
 */
`timescale 1ns/100ps

module renameLogic import regNumPkg::*, renamePortPkg::*; #(
    parameter int renameWidth = 2,
    parameter int commitWidth = 2
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  renameReqT [renameWidth-1:0]        renameReq,
    input  commitT    [commitWidth-1:0]        commit,
    input  logic                               recover,
    input  physRegT   [renameWidth-1:0]        popped,
    input  freeCountT                          freeCount,
    input  physRegT   [2*renameWidth-1:0]      srcPhys,
    input  physRegT   [renameWidth-1:0]        prevPhys,
    input  physRegT   [renameWidth-1:0]        rrmtData,
    output logic [$clog2(renameWidth+1)-1:0]   popCount,
    output logic      [commitWidth-1:0]        pushValid,
    output physRegT   [commitWidth-1:0]        pushData,
    output logic [$clog2(commitWidth+1)-1:0]   commitAdvance,
    output logic                               rewind,
    output logic      [renameWidth-1:0]        rmtWriteEn,
    output logRegT    [renameWidth-1:0]        rmtWriteIdx,
    output physRegT   [renameWidth-1:0]        rmtWriteData,
    output logRegT    [2*renameWidth-1:0]      srcIdx,
    output logRegT    [renameWidth-1:0]        dstIdx,
    output logRegT                             rrmtIdx,
    output renameRespT [renameWidth-1:0]       renameResp,
    output logic                               allocatable,
    output logic                               recovering
);

    localparam int recoverSteps = logRegNum / renameWidth;
    localparam int stepW = $clog2(recoverSteps + 1);
    localparam int popW = $clog2(renameWidth + 1);

    logic [stepW-1:0]       recoverCnt;
    logRegT                 recoverIdx;
    logic [renameWidth-1:0] writer;
    logic [popW-1:0]        popNum;

    // Recovery sequencer copying one block of entries per cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            recoverCnt <= '0;
            recoverIdx <= '0;
        end else if (recover) begin
            recoverCnt <= stepW'(recoverSteps);
            recoverIdx <= '0;
        end else if (recoverCnt != '0) begin
            recoverCnt <= recoverCnt - 1'b1;
            recoverIdx <= recoverIdx + logRegT'(renameWidth);
        end
    end

    assign recovering = (recoverCnt != '0);
    assign rewind = recover;
    assign rrmtIdx = recoverIdx;
    assign allocatable = !recovering && (freeCount >= freeCountT'(renameWidth));
    assign popCount = allocatable ? popNum : '0;

    // Allocation and intra-group bypass
    always_comb begin
        popNum = '0;
        for (int i = 0; i < renameWidth; i++) begin
            writer[i] = renameReq[i].valid && renameReq[i].writeReg;
            srcIdx[2*i] = renameReq[i].logSrc1;
            srcIdx[2*i+1] = renameReq[i].logSrc2;
            dstIdx[i] = renameReq[i].logDst;

            renameResp[i].phyDst = writer[i] ? popped[popNum] : '0;
            renameResp[i].phySrc1 = srcPhys[2*i];
            renameResp[i].phySrc2 = srcPhys[2*i+1];
            renameResp[i].phyPrev = prevPhys[i];

            // Youngest older writer of the same register wins
            for (int j = 0; j < i; j++) begin
                if (writer[j] && renameReq[j].logDst == renameReq[i].logSrc1) begin
                    renameResp[i].phySrc1 = renameResp[j].phyDst;
                end
                if (writer[j] && renameReq[j].logDst == renameReq[i].logSrc2) begin
                    renameResp[i].phySrc2 = renameResp[j].phyDst;
                end
                if (writer[j] && renameReq[j].logDst == renameReq[i].logDst) begin
                    renameResp[i].phyPrev = renameResp[j].phyDst;
                end
            end

            if (writer[i]) begin
                popNum = popNum + 1'b1;
            end
        end
    end

    // Map writes come from rename, or from the retirement map while recovering
    always_comb begin
        for (int i = 0; i < renameWidth; i++) begin
            if (recovering) begin
                rmtWriteEn[i] = 1'b1;
                rmtWriteIdx[i] = recoverIdx + logRegT'(i);
                rmtWriteData[i] = rrmtData[i];
            end else begin
                rmtWriteEn[i] = writer[i] && allocatable;
                rmtWriteIdx[i] = renameReq[i].logDst;
                rmtWriteData[i] = renameResp[i].phyDst;
            end
        end
    end

    // Each retiring writer frees its old register
    always_comb begin
        commitAdvance = '0;
        for (int i = 0; i < commitWidth; i++) begin
            pushValid[i] = commit[i].valid && commit[i].writeReg;
            pushData[i] = commit[i].phyPrev;
            if (pushValid[i]) begin
                commitAdvance = commitAdvance + 1'b1;
            end
        end
    end

endmodule

/* rename/renameMapTable.sv */
/*
 * Speculative rename map table
 * Logical to physical map read for sources and previous mappings,
 * written by rename or by the recovery copy
 */
`timescale 1ns/100ps

module renameMapTable import regNumPkg::*; #(
    parameter int renameWidth = 2
) (
    input  logic                        clk,
    input  logic                        rstN,

    // Two source reads per lane
    input  logRegT  [2*renameWidth-1:0] srcIdx,
    output physRegT [2*renameWidth-1:0] srcPhys,

    // Current mapping of each destination
    input  logRegT  [renameWidth-1:0]   dstIdx,
    output physRegT [renameWidth-1:0]   prevPhys,

    // Write ports
    input  logic    [renameWidth-1:0]   writeEn,
    input  logRegT  [renameWidth-1:0]   writeIdx,
    input  physRegT [renameWidth-1:0]   writeData
);

    physRegT mapTable [logRegNum];

    always_comb begin
        for (int i = 0; i < 2 * renameWidth; i++) begin
            srcPhys[i] = mapTable[srcIdx[i]];
        end
    end

    always_comb begin
        for (int i = 0; i < renameWidth; i++) begin
            prevPhys[i] = mapTable[dstIdx[i]];
        end
    end

    // Later lanes are younger, so their write lands last
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < logRegNum; i++) begin
                mapTable[i] <= physRegT'(i);
            end
        end else begin
            for (int i = 0; i < renameWidth; i++) begin
                if (writeEn[i]) begin
                    mapTable[writeIdx[i]] <= writeData[i];
                end
            end
        end
    end

endmodule

/* rename/retireMapTable.sv */
/*
 * Retirement map table
 * Committed logical to physical map, updated at commit and
 * read in consecutive blocks to rebuild the speculative map
 */
`timescale 1ns/100ps

module retireMapTable import regNumPkg::*, renamePortPkg::*; #(
    parameter int renameWidth = 2,
    parameter int commitWidth = 2
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  commitT  [commitWidth-1:0] commit,
    input  logRegT                    readIdx,
    output physRegT [renameWidth-1:0] readData
);

    physRegT mapTable [logRegNum];

    // Block read for the recovery copy
    always_comb begin
        for (int i = 0; i < renameWidth; i++) begin
            readData[i] = mapTable[readIdx + logRegT'(i)];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < logRegNum; i++) begin
                mapTable[i] <= physRegT'(i);
            end
        end else begin
            for (int i = 0; i < commitWidth; i++) begin
                if (commit[i].valid && commit[i].writeReg) begin
                    mapTable[commit[i].logDst] <= commit[i].phyDst;
                end
            end
        end
    end

endmodule

/* rtl/renameUnit.sv */
/*
 * Register rename unit
 * Top level joining the rename controller, both map tables
 * and the physical register free list
 */
`timescale 1ns/100ps

module renameUnit import regNumPkg::*, renamePortPkg::*; #(
    parameter int renameWidth = 2,
    parameter int commitWidth = 2
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  renameReqT  [renameWidth-1:0] renameReq,
    input  commitT     [commitWidth-1:0] commit,
    input  logic                         recover,
    output renameRespT [renameWidth-1:0] renameResp,
    output logic                         allocatable,
    output logic                         recovering
);

    localparam int popW = $clog2(renameWidth + 1);
    localparam int pushW = $clog2(commitWidth + 1);

    // Free list
    logic [popW-1:0]              popCount;
    physRegT [renameWidth-1:0]    popped;
    logic [commitWidth-1:0]       pushValid;
    physRegT [commitWidth-1:0]    pushData;
    logic [pushW-1:0]             commitAdvance;
    logic                         rewind;
    freeCountT                    freeCount;

    // Map tables
    logRegT  [2*renameWidth-1:0]  srcIdx;
    physRegT [2*renameWidth-1:0]  srcPhys;
    logRegT  [renameWidth-1:0]    dstIdx;
    physRegT [renameWidth-1:0]    prevPhys;
    logic    [renameWidth-1:0]    rmtWriteEn;
    logRegT  [renameWidth-1:0]    rmtWriteIdx;
    physRegT [renameWidth-1:0]    rmtWriteData;
    logRegT                       rrmtIdx;
    physRegT [renameWidth-1:0]    rrmtData;

    renameLogic #(
        .renameWidth(renameWidth),
        .commitWidth(commitWidth)
    ) ctrl (
        .clk(clk), .rstN(rstN),
        .renameReq(renameReq), .commit(commit), .recover(recover),
        .popped(popped), .freeCount(freeCount),
        .srcPhys(srcPhys), .prevPhys(prevPhys), .rrmtData(rrmtData),
        .popCount(popCount), .pushValid(pushValid), .pushData(pushData),
        .commitAdvance(commitAdvance), .rewind(rewind),
        .rmtWriteEn(rmtWriteEn), .rmtWriteIdx(rmtWriteIdx), .rmtWriteData(rmtWriteData),
        .srcIdx(srcIdx), .dstIdx(dstIdx), .rrmtIdx(rrmtIdx),
        .renameResp(renameResp), .allocatable(allocatable), .recovering(recovering)
    );

    freeList #(
        .renameWidth(renameWidth),
        .commitWidth(commitWidth)
    ) freeRegs (
        .clk(clk), .rstN(rstN),
        .popCount(popCount), .popped(popped),
        .pushValid(pushValid), .pushData(pushData),
        .commitAdvance(commitAdvance), .rewind(rewind), .count(freeCount)
    );

    renameMapTable #(
        .renameWidth(renameWidth)
    ) rmt (
        .clk(clk), .rstN(rstN),
        .srcIdx(srcIdx), .srcPhys(srcPhys),
        .dstIdx(dstIdx), .prevPhys(prevPhys),
        .writeEn(rmtWriteEn), .writeIdx(rmtWriteIdx), .writeData(rmtWriteData)
    );

    retireMapTable #(
        .renameWidth(renameWidth),
        .commitWidth(commitWidth)
    ) rrmt (
        .clk(clk), .rstN(rstN),
        .commit(commit), .readIdx(rrmtIdx), .readData(rrmtData)
    );

endmodule

/* verif/renameVectors.svh */
/*
 * Rename stage stimulus table
 * Columns: step kind, repeat count, lane 0, lane 1, commit lanes, test name
 * Lane fields are valid, writeReg, logDst, logSrc1, logSrc2
 */
task automatic loadSteps();
    addStep(stepRename, 1, makeReq(1, 0, 3, 1, 2), noReq, 0, "resetIdentity");
    addStep(stepRename, 1, makeReq(1, 1, 5, 1, 2), makeReq(1, 1, 6, 5, 5), 0, "allocBypass");
    addStep(stepRename, 1, makeReq(1, 1, 7, 7, 0), makeReq(1, 1, 7, 7, 6), 0, "prevBypass");
    // Drains the free list so the last two groups stall
    addStep(stepRename, 8, makeReq(1, 1, 8, 5, 7), makeReq(1, 1, 9, 8, 9), 0, "backPressure");
    addStep(stepRename, 1, makeReq(1, 1, 10, 9, 8), noReq, 0, "stallNoState");
    addStep(stepCommit, 3, noReq, noReq, 2, "commitRecycle");
    // Recycled registers come back in push order
    addStep(stepRename, 3, makeReq(1, 1, 11, 5, 9), makeReq(1, 1, 12, 11, 10), 0, "recycled");
    addStep(stepCommit, 2, noReq, noReq, 2, "commitMore");
    addStep(stepRename, 1, makeReq(1, 1, 1, 2, 3), makeReq(1, 1, 2, 1, 1), 0, "beforeRecover");
    addStep(stepRecover, 1, noReq, noReq, 0, "recoverPulse");
    addStep(stepRename, 1, makeReq(1, 0, 11, 5, 9), makeReq(1, 1, 3, 12, 1), 0, "afterRecover");
    addStep(stepRandom, 300, noReq, noReq, 0, "randomMix");
    addStep(stepIdle, 1, noReq, noReq, 0, "drain");
endtask

/* verif/renameUnitTb.sv */
/*
 * Rename unit testbench
 * Table-driven rename, commit and recovery steps checked against
 * a reference model of both maps and the free list
 */
`timescale 1ns/100ps

module renameUnitTb import regNumPkg::*, renamePortPkg::*; ();

    localparam int renameWidth = 2;
    localparam int commitWidth = 2;
    localparam int freeDepth = physRegNum - logRegNum;
    localparam int maxRecoverWait = 20;

    typedef enum logic [2:0] {
        stepIdle, stepRename, stepCommit, stepRecover, stepRandom
    } stepKindT;

    typedef struct packed {
        stepKindT                    kind;
        logic [9:0]                  reps;
        renameReqT [renameWidth-1:0] lanes;
        logic [1:0]                  commits;
    } stepT;

    localparam renameReqT noReq = '0;

    logic                         clk;
    logic                         rstN;
    renameReqT  [renameWidth-1:0] renameReq;
    commitT     [commitWidth-1:0] commit;
    logic                         recover;
    renameRespT [renameWidth-1:0] renameResp;
    logic                         allocatable;
    logic                         recovering;

    // Reference model whose pointers count up without wrapping
    physRegT specMap [logRegNum];
    physRegT commMap [logRegNum];
    physRegT freeFifo [freeDepth];
    int      headPtr;
    int      tailPtr;
    int      commitPtr;
    commitT  inflight [$];

    stepT        steps [$];
    string       stepNames [$];
    logic [31:0] rndState = 32'd71;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    renameUnit #(
        .renameWidth(renameWidth),
        .commitWidth(commitWidth)
    ) uut (
        .clk(clk), .rstN(rstN),
        .renameReq(renameReq), .commit(commit), .recover(recover),
        .renameResp(renameResp), .allocatable(allocatable), .recovering(recovering)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshiftNext(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic renameReqT makeReq(input int valid, input int writeReg,
                                          input int dst, input int src1, input int src2);
        renameReqT r;
        r.valid = valid[0];
        r.writeReg = writeReg[0];
        r.logDst = logRegT'(dst);
        r.logSrc1 = logRegT'(src1);
        r.logSrc2 = logRegT'(src2);
        return r;
    endfunction

    task automatic addStep(input stepKindT kind, input int reps, input renameReqT lane0,
                           input renameReqT lane1, input int commits, input string name);
        stepT s;
        s.kind = kind;
        s.reps = 10'(reps);
        s.lanes[0] = lane0;
        s.lanes[1] = lane1;
        s.commits = 2'(commits);
        steps.push_back(s);
        stepNames.push_back(name);
    endtask

    `include "renameVectors.svh"

    // Recovery rows may take a full rebuild, so they get a wider budget
    function automatic int rowCycles(input stepT s);
        if (s.kind == stepRecover || s.kind == stepRandom) begin
            return 12 * s.reps;
        end else begin
            return s.reps;
        end
    endfunction

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expVal, input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            $display("error %s %s: expected %h actual %h", testName, what, expVal, actVal);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // One cycle of rename and commit checked in mid-cycle
    task automatic applyStep(input renameReqT [renameWidth-1:0] lanes, input int commits,
                             input string name);
        commitT [commitWidth-1:0] retiring;
        commitT                   entry;
        renameRespT               expResp;
        logic                     expAlloc;
        @(posedge clk);
        #1;
        for (int i = 0; i < commitWidth; i++) begin
            retiring[i] = '0;
            if (i < commits && inflight.size() > 0) begin
                retiring[i] = inflight.pop_front();
            end
        end
        renameReq = lanes;
        commit = retiring;
        recover = 1'b0;
        #1;
        checkValue(name, "recovering", 0, recovering);
        expAlloc = (tailPtr - headPtr) >= renameWidth;
        checkValue(name, "allocatable", expAlloc, allocatable);
        if (expAlloc) begin
            // Updating the map lane by lane gives the in-group bypass
            for (int i = 0; i < renameWidth; i++) begin
                expResp.phySrc1 = specMap[lanes[i].logSrc1];
                expResp.phySrc2 = specMap[lanes[i].logSrc2];
                expResp.phyPrev = specMap[lanes[i].logDst];
                expResp.phyDst = '0;
                if (lanes[i].valid && lanes[i].writeReg) begin
                    expResp.phyDst = freeFifo[headPtr % freeDepth];
                    headPtr++;
                    specMap[lanes[i].logDst] = expResp.phyDst;
                    entry = {2'b11, lanes[i].logDst, expResp.phyDst, expResp.phyPrev};
                    inflight.push_back(entry);
                end
                if (lanes[i].valid) begin
                    checkValue(name, $sformatf("lane %0d response", i), expResp, renameResp[i]);
                end
            end
        end
        for (int i = 0; i < commitWidth; i++) begin
            if (retiring[i].valid && retiring[i].writeReg) begin
                commMap[retiring[i].logDst] = retiring[i].phyDst;
                freeFifo[tailPtr % freeDepth] = retiring[i].phyPrev;
                tailPtr++;
                commitPtr++;
            end
        end
    endtask

    task automatic runRecover(input string name);
        int highCycles;
        @(posedge clk);
        #1;
        renameReq = '0;
        commit = '0;
        recover = 1'b1;
        headPtr = commitPtr;
        inflight.delete();
        for (int i = 0; i < logRegNum; i++) begin
            specMap[i] = commMap[i];
        end
        @(posedge clk);
        #1;
        recover = 1'b0;
        #1;
        highCycles = 0;
        while (recovering === 1'b1 && highCycles <= maxRecoverWait) begin
            checkValue(name, "allocatable while recovering", 0, allocatable);
            highCycles++;
            @(posedge clk);
            #2;
        end
        checkValue(name, "recovering cycles", logRegNum / renameWidth, highCycles);
        checkValue(name, "allocatable after recovery", (tailPtr - headPtr) >= renameWidth,
                   allocatable);
    endtask

    // About one row in sixteen is a recovery
    task automatic runRandom(input string name);
        renameReqT [renameWidth-1:0] lanes;
        rndState = xorshiftNext(rndState);
        if (rndState[3:0] == 4'd0) begin
            runRecover(name);
        end else begin
            for (int i = 0; i < renameWidth; i++) begin
                rndState = xorshiftNext(rndState);
                lanes[i] = makeReq(rndState[0] | rndState[1], rndState[2] | rndState[3],
                                   rndState[7:4], rndState[11:8], rndState[15:12]);
            end
            applyStep(lanes, rndState[17:16], name);
        end
    endtask

    initial begin
        int total;
        rstN = 1'b0;
        renameReq = '0;
        commit = '0;
        recover = 1'b0;
        for (int i = 0; i < logRegNum; i++) begin
            specMap[i] = physRegT'(i);
            commMap[i] = physRegT'(i);
        end
        for (int i = 0; i < freeDepth; i++) begin
            freeFifo[i] = physRegT'(logRegNum + i);
        end
        headPtr = 0;
        tailPtr = freeDepth;
        commitPtr = 0;
        loadSteps();
        total = 0;
        foreach (steps[k]) begin
            total += rowCycles(steps[k]);
        end
        cycleLimit = 2 * total + 100;

        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
        #1;
        checkValue("resetState", "allocatable", 1, allocatable);
        checkValue("resetState", "recovering", 0, recovering);

        foreach (steps[k]) begin
            for (int r = 0; r < steps[k].reps; r++) begin
                case (steps[k].kind)
                    stepRecover: runRecover(stepNames[k]);
                    stepRandom:  runRandom(stepNames[k]);
                    default:     applyStep(steps[k].lanes, steps[k].commits, stepNames[k]);
                endcase
            end
        end

        @(posedge clk);
        #1;
        renameReq = '0;
        commit = '0;
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verif
common/regNumPkg.sv
common/renamePortPkg.sv
rename/freeList.sv
rename/renameMapTable.sv
rename/retireMapTable.sv
rename/renameLogic.sv
rtl/renameUnit.sv
verif/renameUnitTb.sv
